// ==== rtl/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int XLEN    = 16;
    localparam int REG_SEL = 4;
    localparam int TAG_W   = 6;

    // latency counter wide enough for LAT_MUL
    localparam int LAT_W   = 4;
    localparam int LAT_ALU = 1;
    localparam int LAT_MUL = 8;

    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_MUL = 3'd3,
        OP_NOP = 3'd4
    } rob_op_e;

    typedef struct packed {
        logic [XLEN-1:0]    pc;
        rob_op_e            op;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic               dst_valid;
        logic [REG_SEL-1:0] dst;
    } rob_inst_t;

    typedef struct packed {
        rob_tag_t           tag;
        logic [XLEN-1:0]    pc;
        logic               dst_valid;
        logic [REG_SEL-1:0] dst;
    } rob_alloc_t;

    typedef struct packed {
        rob_tag_t        tag;
        rob_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } rob_issue_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [XLEN-1:0] result;
    } rob_finish_t;

    typedef struct packed {
        logic               valid;
        logic               we;
        logic [REG_SEL-1:0] dst;
        logic [XLEN-1:0]    value;
        logic [XLEN-1:0]    pc;
    } rob_commit_t;

    // cycles from issue to finish
    function automatic logic [LAT_W-1:0] op_latency(rob_op_e op);
        if (op == OP_MUL) begin
            return LAT_W'(LAT_MUL);
        end
        return LAT_W'(LAT_ALU);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/rob_dispatch.sv ====
`default_nettype none

module rob_dispatch #(
    parameter int ROB_DEPTH = 8
) (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire rob_pkg::rob_inst_t inst_i,
    input  wire                     inst_valid_i,
    output logic                    inst_ready_o,
    input  wire                     alloc_ready_i,
    input  wire                     issue_ready_i,
    output rob_pkg::rob_alloc_t     alloc_o,
    output logic                    alloc_valid_o,
    output rob_pkg::rob_issue_t     issue_o,
    output logic                    issue_valid_o
);
    import rob_pkg::*;

    rob_tag_t tail;
    logic     xfer;

    // needs a free rob entry and a free exec slot at once
    assign inst_ready_o = alloc_ready_i & issue_ready_i;
    assign xfer = inst_valid_i & inst_ready_o;

    assign alloc_valid_o = xfer;
    assign issue_valid_o = xfer;

    // a nop has no result to retire, so it never claims a register
    assign alloc_o = '{
        tag:       tail,
        pc:        inst_i.pc,
        dst_valid: inst_i.dst_valid & (inst_i.op != OP_NOP),
        dst:       inst_i.dst
    };

    assign issue_o = '{
        tag: tail,
        op:  inst_i.op,
        a:   inst_i.a,
        b:   inst_i.b
    };

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tail <= '0;
        end else if (xfer) begin
            // wrap at rob depth
            if (tail == TAG_W'(ROB_DEPTH - 1)) begin
                tail <= '0;
            end else begin
                tail <= tail + 1'b1;
            end
        end
    end

    a_alloc_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_valid_o |-> alloc_ready_i)
        else $error("allocation sent to a full reorder buffer");

    // source must hold a stalled instruction
    a_inst_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        inst_valid_i && !inst_ready_o |=> inst_valid_i && $stable(inst_i))
        else $error("instruction changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/rob_buffer.sv ====
`default_nettype none

module rob_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire rob_pkg::rob_alloc_t  alloc_i,
    input  wire                       alloc_valid_i,
    output logic                      alloc_ready_o,
    input  wire rob_pkg::rob_finish_t finish_i,
    output rob_pkg::rob_commit_t      commit_o
);
    import rob_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);

    // per-entry state
    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_finish;
    logic [ROB_DEPTH-1:0] ent_dst_valid;
    logic [REG_SEL-1:0]   ent_dst    [ROB_DEPTH];
    logic [XLEN-1:0]      ent_pc     [ROB_DEPTH];
    logic [XLEN-1:0]      ent_result [ROB_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W:0]   count;

    logic [PTR_W-1:0] alloc_idx;
    logic [PTR_W-1:0] fin_idx;
    logic             do_commit;

    // tags only ever span the first ROB_DEPTH slots
    assign alloc_idx = alloc_i.tag[PTR_W-1:0];
    assign fin_idx   = finish_i.tag[PTR_W-1:0];

    assign alloc_ready_o = (count != (PTR_W + 1)'(ROB_DEPTH));

    // retire only the oldest entry, once it has finished
    assign do_commit = ent_valid[head] & ent_finish[head];

    assign commit_o = '{
        valid: do_commit,
        we:    ent_dst_valid[head],
        dst:   ent_dst[head],
        value: ent_result[head],
        pc:    ent_pc[head]
    };

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ent_valid  <= '0;
            ent_finish <= '0;
            head       <= '0;
            count      <= '0;
        end else begin
            if (alloc_valid_i) begin
                ent_valid[alloc_idx]  <= 1'b1;
                ent_finish[alloc_idx] <= 1'b0;
            end
            if (finish_i.valid) begin
                ent_finish[fin_idx] <= 1'b1;
            end
            if (do_commit) begin
                ent_valid[head] <= 1'b0;
                // head wraps by itself at a power-of-two depth
                head <= head + 1'b1;
            end
            count <= count + (PTR_W + 1)'(alloc_valid_i) - (PTR_W + 1)'(do_commit);
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            ent_dst_valid[alloc_idx] <= alloc_i.dst_valid;
            ent_dst[alloc_idx]       <= alloc_i.dst;
            ent_pc[alloc_idx]        <= alloc_i.pc;
        end
        if (finish_i.valid) begin
            ent_result[fin_idx] <= finish_i.result;
        end
    end

    a_finish_live: assert property (@(posedge clk_i) disable iff (reset_i)
        finish_i.valid |-> ent_valid[fin_idx] && !ent_finish[fin_idx])
        else $error("finish for idle or already finished entry %0d", fin_idx);

    a_alloc_free: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_valid_i |-> !ent_valid[alloc_idx])
        else $error("allocation onto live entry %0d", alloc_idx);

endmodule

`default_nettype wire

// ==== rtl/rob_exec_unit.sv ====
`default_nettype none

module rob_exec_unit #(
    parameter int EXEC_SLOTS = 4
) (
    input  wire                      clk_i,
    input  wire                      reset_i,
    input  wire rob_pkg::rob_issue_t issue_i,
    input  wire                      issue_valid_i,
    output logic                     issue_ready_o,
    output rob_pkg::rob_finish_t     finish_o
);
    import rob_pkg::*;

    localparam int SLOT_W = (EXEC_SLOTS > 1) ? $clog2(EXEC_SLOTS) : 1;

    typedef struct packed {
        rob_tag_t         tag;
        logic [LAT_W-1:0] cnt;
        logic [XLEN-1:0]  result;
    } slot_t;

    logic [EXEC_SLOTS-1:0] busy;
    logic [EXEC_SLOTS-1:0] done;
    slot_t                 slots [EXEC_SLOTS];
    logic [SLOT_W-1:0]     free_idx;
    logic [SLOT_W-1:0]     done_idx;
    logic                  any_done;
    logic                  do_issue;

    // mul keeps only the low half of the product
    function automatic logic [XLEN-1:0] alu(rob_op_e op, logic [XLEN-1:0] a,
                                            logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    always_comb begin
        free_idx = '0;
        done_idx = '0;
        for (int i = 0; i < EXEC_SLOTS; i++) begin
            done[i] = busy[i] && (slots[i].cnt == '0);
        end
        // scan downward so the lowest slot wins
        for (int i = EXEC_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = SLOT_W'(i);
            end
            if (done[i]) begin
                done_idx = SLOT_W'(i);
            end
        end
    end

    assign issue_ready_o = ~&busy;
    assign any_done = |done;
    assign do_issue = issue_valid_i & issue_ready_o;

    assign finish_o = '{
        valid:  any_done,
        tag:    slots[done_idx].tag,
        result: slots[done_idx].result
    };

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy <= '0;
        end else begin
            if (any_done) begin
                busy[done_idx] <= 1'b0;
            end
            if (do_issue) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        // a done slot holds at zero until reported
        for (int i = 0; i < EXEC_SLOTS; i++) begin
            if (busy[i] && slots[i].cnt != '0) begin
                slots[i].cnt <= slots[i].cnt - 1'b1;
            end
        end
        // load latency minus one so finish shows up L cycles later
        if (do_issue) begin
            slots[free_idx] <= '{
                tag:    issue_i.tag,
                cnt:    op_latency(issue_i.op) - 1'b1,
                result: alu(issue_i.op, issue_i.a, issue_i.b)
            };
        end
    end

    a_issue_room: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_valid_i |-> issue_ready_o)
        else $error("issue into a full execution unit");

endmodule

`default_nettype wire

// ==== rtl/rob_arch_regfile.sv ====
`default_nettype none

module rob_arch_regfile (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire rob_pkg::rob_commit_t  commit_i,
    input  wire [rob_pkg::REG_SEL-1:0] rd_addr_i,
    output logic [rob_pkg::XLEN-1:0]   rd_data_o
);
    import rob_pkg::*;

    localparam int NUM_REGS = 2 ** REG_SEL;

    logic [XLEN-1:0] regs [NUM_REGS];

    // only retired results reach here
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i.valid && commit_i.we) begin
            regs[commit_i.dst] <= commit_i.value;
        end
    end

    // combinational observation port
    assign rd_data_o = regs[rd_addr_i];

endmodule

`default_nettype wire

// ==== rtl/rob_core_top.sv ====
`default_nettype none

module rob_core_top #(
    parameter int ROB_DEPTH  = 8,
    parameter int EXEC_SLOTS = 4
) (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire rob_pkg::rob_inst_t    inst_i,
    input  wire                        inst_valid_i,
    output wire                        inst_ready_o,
    output wire rob_pkg::rob_commit_t  commit_o,
    input  wire [rob_pkg::REG_SEL-1:0] rd_addr_i,
    output wire [rob_pkg::XLEN-1:0]    rd_data_o
);
    import rob_pkg::*;

    rob_alloc_t  alloc;
    logic        alloc_valid;
    logic        alloc_ready;
    rob_issue_t  issue;
    logic        issue_valid;
    logic        issue_ready;
    rob_finish_t finish;

    rob_dispatch #(
        .ROB_DEPTH(ROB_DEPTH)
    ) i_dispatch (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .alloc_ready_i(alloc_ready),
        .issue_ready_i(issue_ready),
        .alloc_o      (alloc),
        .alloc_valid_o(alloc_valid),
        .issue_o      (issue),
        .issue_valid_o(issue_valid)
    );

    rob_exec_unit #(
        .EXEC_SLOTS(EXEC_SLOTS)
    ) i_exec (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .issue_i      (issue),
        .issue_valid_i(issue_valid),
        .issue_ready_o(issue_ready),
        .finish_o     (finish)
    );

    rob_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) i_rob (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .alloc_i      (alloc),
        .alloc_valid_i(alloc_valid),
        .alloc_ready_o(alloc_ready),
        .finish_i     (finish),
        .commit_o     (commit_o)
    );

    rob_arch_regfile i_arf (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .commit_i (commit_o),
        .rd_addr_i(rd_addr_i),
        .rd_data_o(rd_data_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_rob_core.sv ====
`default_nettype none

module tb_rob_core;
    timeunit 1ns;
    timeprecision 100ps;

    import rob_pkg::*;

    localparam int ROB_DEPTH    = 8;
    localparam int EXEC_SLOTS   = 4;
    localparam int NUM_REGS     = 2 ** REG_SEL;
    localparam int RANDOM_COUNT = 200;
    localparam int STALL_LIMIT  = 100;
    localparam int DRAIN_LIMIT  = 500;

    logic               clk_i;
    logic               reset_i;
    rob_inst_t          inst_i;
    logic               inst_valid_i;
    logic               inst_ready_o;
    rob_commit_t        commit_o;
    logic [REG_SEL-1:0] rd_addr_i;
    logic [XLEN-1:0]    rd_data_o;

    // read port is shared by the register scan and the per-commit check
    logic               scanning;
    logic [REG_SEL-1:0] scan_addr;
    logic [REG_SEL-1:0] chk_addr;
    logic [REG_SEL-1:0] chk_dst;
    logic [XLEN-1:0]    chk_val;
    logic               chk_armed;

    rob_inst_t       exp_q[$];
    logic [XLEN-1:0] shadow [NUM_REGS];
    logic [31:0]     rng;
    logic [XLEN-1:0] pc;
    logic            directed;
    logic            saw_full;
    logic            aborted;
    int              accepted;
    int              commits;
    int              retired;
    int              errors;
    int              commit_errors;
    int              prop_errors;
    int              timeouts;

    assign rd_addr_i = scanning ? scan_addr : chk_addr;

    rob_core_top #(
        .ROB_DEPTH (ROB_DEPTH),
        .EXEC_SLOTS(EXEC_SLOTS)
    ) i_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .inst_valid_i(inst_valid_i),
        .inst_ready_o(inst_ready_o),
        .commit_o    (commit_o),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // low 16 bits of the operation
    function automatic logic [XLEN-1:0] expected_value(rob_op_e op, logic [XLEN-1:0] a,
                                                       logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 1'b1;
            OP_XOR:  return a ^ b;
            OP_MUL:  return prod[XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    function automatic rob_inst_t build_inst(rob_op_e op);
        rob_inst_t   inst;
        logic [31:0] r;
        r = next_rand();
        inst.pc = pc;
        inst.op = op;
        inst.a = r[15:0];
        inst.b = r[31:16];
        r = next_rand();
        inst.dst_valid = r[0];
        inst.dst = r[4:1];
        return inst;
    endfunction

    task automatic idle_cycle();
        inst_valid_i = 1'b0;
        @(posedge clk_i);
        #10;
    endtask

    // holds the instruction until it is taken
    task automatic send_inst(rob_inst_t inst);
        int   waited;
        logic took;
        waited = 0;
        took = 1'b0;
        inst_i = inst;
        inst_valid_i = 1'b1;
        while (!took && !aborted) begin
            took = inst_ready_o;
            if (!took && directed) begin
                saw_full = 1'b1;
            end
            @(posedge clk_i);
            #10;
            waited++;
            if (!took && waited > STALL_LIMIT) begin
                $display("timeout: instruction with pc %0d was never accepted", inst.pc);
                timeouts++;
                aborted = 1'b1;
            end
        end
        inst_valid_i = 1'b0;
        if (took) begin
            exp_q.push_back(inst);
            accepted++;
            pc = pc + 16'd1;
        end
    endtask

    task automatic check_regs();
        scanning = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            scan_addr = REG_SEL'(i);
            @(negedge clk_i);
            assert (rd_data_o == shadow[i]) else begin
                errors++;
                $display("Fail %0t: register %0d reads %h, expected %h",
                         $time, i, rd_data_o, shadow[i]);
            end
            @(posedge clk_i);
            #10;
        end
        scanning = 1'b0;
    endtask

    // committed count as seen by the dut after each edge
    always @(posedge clk_i) begin
        #10;
        retired = commits;
        chk_addr = chk_dst;
    end

    always @(negedge clk_i) begin : commit_check
        rob_inst_t       exp;
        logic [XLEN-1:0] val;
        logic            exp_we;
        if (!reset_i) begin
            // register written by the previous commit
            if (chk_armed) begin
                assert (rd_data_o == chk_val) else begin
                    commit_errors++;
                    $display("Fail %0t: register %0d reads %h after commit of %h",
                             $time, chk_dst, rd_data_o, chk_val);
                end
            end
            chk_armed = 1'b0;
            if (commit_o.valid) begin
                commits++;
                if (exp_q.size() == 0) begin
                    commit_errors++;
                    $display("Fail %0t: commit of pc %0d with nothing outstanding",
                             $time, commit_o.pc);
                end else begin
                    exp = exp_q.pop_front();
                    val = expected_value(exp.op, exp.a, exp.b);
                    exp_we = exp.dst_valid && (exp.op != OP_NOP);
                    assert (commit_o.pc == exp.pc && commit_o.dst == exp.dst
                            && commit_o.we == exp_we) else begin
                        commit_errors++;
                        $display("Fail %0t: commit pc %0d dst %0d we %0b, expected %0d %0d %0b",
                                 $time, commit_o.pc, commit_o.dst, commit_o.we,
                                 exp.pc, exp.dst, exp_we);
                    end
                    assert (commit_o.value == val) else begin
                        commit_errors++;
                        $display("Fail %0t: pc %0d commits value %h, expected %h",
                                 $time, exp.pc, commit_o.value, val);
                    end
                    if (exp_we) begin
                        shadow[exp.dst] = val;
                        chk_dst = exp.dst;
                        chk_val = val;
                        chk_armed = 1'b1;
                    end
                end
            end
        end
    end

    a_idle_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        (accepted == retired) |-> inst_ready_o && !commit_o.valid)
        else begin
            prop_errors++;
            $display("Fail %0t: empty core is not ready or commits", $time);
        end

    // in the directed phase only the reorder buffer can fill
    a_stall_only_full: assert property (@(posedge clk_i) disable iff (reset_i)
        directed && !inst_ready_o |-> (accepted - retired) == ROB_DEPTH)
        else begin
            prop_errors++;
            $display("Fail %0t: stalled with %0d outstanding", $time, accepted - retired);
        end

    initial begin
        int          total;
        int          waited;
        logic [31:0] r;
        rng = 32'd15337;
        pc = '0;
        reset_i = 1'b1;
        inst_i = '0;
        inst_valid_i = 1'b0;
        scanning = 1'b1;
        scan_addr = '0;
        chk_dst = '0;
        chk_val = '0;
        chk_armed = 1'b0;
        directed = 1'b0;
        saw_full = 1'b0;
        aborted = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        #10;
        reset_i = 1'b0;

        assert (inst_ready_o && !commit_o.valid) else begin
            errors++;
            $display("Fail %0t: core not idle after reset", $time);
        end
        check_regs();

        // old mul at the head while younger adds pile up behind it
        directed = 1'b1;
        send_inst(build_inst(OP_MUL));
        for (int n = 0; n < 10 && !aborted; n++) begin
            send_inst(build_inst(OP_ADD));
        end
        directed = 1'b0;
        assert (saw_full) else begin
            errors++;
            $display("Fail %0t: input never stalled on a full reorder buffer", $time);
        end

        for (int n = 0; n < RANDOM_COUNT && !aborted; n++) begin
            r = next_rand();
            if (r[1:0] == 2'b00) begin
                idle_cycle();
            end
            send_inst(build_inst(rob_op_e'(3'(r[31:8] % 24'd5))));
        end

        waited = 0;
        while (!aborted && (exp_q.size() != 0 || chk_armed)) begin
            @(posedge clk_i);
            #10;
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("timeout: reorder buffer did not drain");
                timeouts++;
                aborted = 1'b1;
            end
        end

        check_regs();
        assert (commits == accepted && exp_q.size() == 0) else begin
            errors++;
            $display("Fail %0t: %0d commits for %0d accepted instructions",
                     $time, commits, accepted);
        end

        total = errors + commit_errors + prop_errors + timeouts;
        $display(
            "errors %0d general %0d commit %0d property %0d timeout, %0d accepted %0d committed",
            errors, commit_errors, prop_errors, timeouts, accepted, commits);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/rob_pkg.sv
rtl/rob_dispatch.sv
rtl/rob_buffer.sv
rtl/rob_exec_unit.sv
rtl/rob_arch_regfile.sv
rtl/rob_core_top.sv
sim/tb_rob_core.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing --timescale 1ns/100ps
TOP       = tb_rob_core
FILELIST  = all.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJDIR)
